// ==== verilog/adc_sample_pkg.sv ====
/*
 * ADC sample types
 * one converter sample as carried on the board, and the pair of
 * channel samples that is captured together every data clock
 */

package adc_sample_pkg;

	// converter resolution
	// samples are zero extended from here up to SAMPLE_BITS
	localparam int ADC_BITS = 14;

	// board width of one sample lane
	localparam int SAMPLE_BITS = 16;

	typedef logic [SAMPLE_BITS-1:0] adc_sample_t;

	// two channels side by side, 32 bits in total
	// chan_a sits in the upper half, chan_b in the lower half
	// this is also the word layout of the capture memory
	typedef struct packed {
		adc_sample_t chan_a;
		adc_sample_t chan_b;
	} sample_pair_t;

endpackage

// ==== verilog/capture_mem_pkg.sv ====
/*
 * Capture memory definitions
 * depth, address and word types, the write port bundle and the
 * states of the capture sequencer
 */

package capture_mem_pkg;

	// memory geometry
	localparam int CAPTURE_DEPTH = 1024;
	localparam int ADDR_BITS = $clog2(CAPTURE_DEPTH);
	localparam int WORD_BITS = 32;

	typedef logic [ADDR_BITS-1:0] cap_addr_t;
	typedef logic [WORD_BITS-1:0] cap_word_t;

	// highest address a capture writes
	localparam cap_addr_t LAST_ADDR = '1;

	// flops on the enable crossing
	localparam int ENABLE_SYNC_STAGES = 3;

	// one memory write per cycle, strobed by we
	typedef struct packed {
		logic      we;
		cap_addr_t addr;
		cap_word_t data;
	} mem_write_t;

	// capture sequencer
	// idle until a request, fill the memory, then hold at full
	typedef enum logic [1:0] {
		CAP_IDLE = 2'd0,
		CAP_FILL = 2'd1,
		CAP_FULL = 2'd2
	} capture_state_t;

endpackage

// ==== verilog/capture_enable_sync.sv ====
/*
 * Capture enable synchronizer
 * brings the asynchronous enable level into the data clock domain
 * and turns its edges into a capture request level
 */

`timescale 1ns/1ps

module capture_enable_sync (
	input  logic data_clk_div,
	input  logic rst_n,
	input  logic capture_enable,
	output logic capture_req
);

	import capture_mem_pkg::*;

	logic [ENABLE_SYNC_STAGES-1:0] sync_q;
	logic                          enable_sync;
	logic                          enable_q;
	logic                          enable_rise;
	logic                          enable_fall;

	// metastability chain, oldest stage on the msb
	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[ENABLE_SYNC_STAGES-2:0], capture_enable};
		end
	end

	assign enable_sync = sync_q[ENABLE_SYNC_STAGES-1];

	// edge detect against the previous synchronized value
	assign enable_rise = enable_sync & ~enable_q;
	assign enable_fall = ~enable_sync & enable_q;

	// request follows the edges rather than the level itself
	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			enable_q    <= 1'b0;
			capture_req <= 1'b0;
		end else begin
			enable_q <= enable_sync;
			if (enable_rise) begin
				capture_req <= 1'b1;
			end else if (enable_fall) begin
				capture_req <= 1'b0;
			end
		end
	end

endmodule

// ==== verilog/capture_addr_gen.sv ====
/*
 * Capture address generator
 * steps the memory address while a capture is requested and registers
 * each sample pair next to its address, reporting when memory is full
 */

`timescale 1ns/1ps

module capture_addr_gen (
	input  logic                        data_clk_div,
	input  logic                        rst_n,
	input  logic                        capture_req,
	input  adc_sample_pkg::sample_pair_t adc_in,
	output capture_mem_pkg::mem_write_t wr,
	output logic                        capture_full
);

	import capture_mem_pkg::*;

	capture_state_t state;
	capture_state_t state_next;

	cap_addr_t addr;
	cap_addr_t addr_next;
	logic      we;
	logic      we_next;
	cap_word_t data;

	// next state and counter
	// address moves before the first write, so word 0 is never filled
	always_comb begin
		state_next = state;
		addr_next  = addr;
		we_next    = 1'b0;

		unique case (state)
			CAP_IDLE: begin
				addr_next = '0;
				if (capture_req) begin
					state_next = CAP_FILL;
					addr_next  = addr + 1'b1;
					we_next    = 1'b1;
				end
			end

			CAP_FILL: begin
				if (!capture_req) begin
					state_next = CAP_IDLE;
					addr_next  = '0;
				end else if (addr == LAST_ADDR) begin
					// last word goes out this cycle
					state_next = CAP_FULL;
				end else begin
					addr_next = addr + 1'b1;
					we_next   = 1'b1;
				end
			end

			CAP_FULL: begin
				if (!capture_req) begin
					state_next = CAP_IDLE;
					addr_next  = '0;
				end
			end

			default: begin
				state_next = CAP_IDLE;
				addr_next  = '0;
			end
		endcase
	end

	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			state <= CAP_IDLE;
			addr  <= '0;
			we    <= 1'b0;
		end else begin
			state <= state_next;
			addr  <= addr_next;
			we    <= we_next;
		end
	end

	// sample payload, lined up with the address of the same cycle
	always_ff @(posedge data_clk_div) begin
		if (capture_req) begin
			data <= adc_in;
		end
	end

	assign wr.we   = we;
	assign wr.addr = addr;
	assign wr.data = data;

	assign capture_full = (state == CAP_FULL);

endmodule

// ==== verilog/capture_ram.sv ====
/*
 * Capture memory
 * 1024 by 32 words with one write port fed by the address generator
 * and one registered read port
 */

`timescale 1ns/1ps

module capture_ram (
	input  logic                        data_clk_div,
	input  capture_mem_pkg::mem_write_t wr,
	input  capture_mem_pkg::cap_addr_t  rd_addr,
	output capture_mem_pkg::cap_word_t  rd_data
);

	import capture_mem_pkg::*;

	cap_word_t mem [CAPTURE_DEPTH];

	// write side
	always_ff @(posedge data_clk_div) begin
		if (wr.we) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// read side, one cycle latency
	// a read of the address being written sees the old word
	always_ff @(posedge data_clk_div) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== verilog/adc_capture_top.sv ====
/*
 * ADC capture top level
 * enable synchronizer, capture sequencer and capture memory,
 * all clocked by the divided data clock
 */

`timescale 1ns/1ps

module adc_capture_top (
	input  logic                         data_clk_div,
	input  logic                         rst_n,
	input  logic                         capture_enable,
	input  adc_sample_pkg::sample_pair_t adc_in,
	input  capture_mem_pkg::cap_addr_t   rd_addr,
	output capture_mem_pkg::cap_word_t   rd_data,
	output logic                         capture_full
);

	import capture_mem_pkg::*;

	logic       capture_req;
	mem_write_t wr;

	// enable crossing
	capture_enable_sync u_enable_sync (
		.data_clk_div   (data_clk_div),
		.rst_n          (rst_n),
		.capture_enable (capture_enable),
		.capture_req    (capture_req)
	);

	// address and sample sequencing
	capture_addr_gen u_addr_gen (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.capture_req  (capture_req),
		.adc_in       (adc_in),
		.wr           (wr),
		.capture_full (capture_full)
	);

	// sample storage, read back through rd_addr
	capture_ram u_capture_ram (
		.data_clk_div (data_clk_div),
		.wr           (wr),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data)
	);

endmodule

// ==== tests/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * free running data clock and a synchronous active low reset
 */

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int CLK_PERIOD_NS = 100,
	parameter int RESET_CYCLES  = 16
) (
	output logic data_clk_div,
	output logic rst_n
);

	initial begin
		data_clk_div = 1'b0;
		forever begin
			#(CLK_PERIOD_NS / 2) data_clk_div = ~data_clk_div;
		end
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge data_clk_div);
		@(negedge data_clk_div);
		rst_n = 1'b1;
	end

endmodule

// ==== tests/tb_adc_capture.sv ====
/*
 * ADC capture testbench
 * runs the capture cases from the cases file, reads the memory back
 * and checks sample order, word layout and the full status
 */

`timescale 1ns/1ps

module tb_adc_capture;

	import adc_sample_pkg::*;
	import capture_mem_pkg::*;

	localparam int RESET_CYCLES  = 16;
	localparam int FULL_HOLD_MIN = 1100;
	localparam int IDLE_MIN      = 8;
	localparam int IDLE_MAX      = 40;
	localparam int CLEAR_WAIT    = 10;
	localparam int MAX_CASES     = 32;

	localparam adc_sample_t ADC_MASK = adc_sample_t'((1 << ADC_BITS) - 1);

	logic         data_clk_div;
	logic         rst_n;
	logic         capture_enable;
	sample_pair_t adc_in = '0;
	cap_addr_t    rd_addr;
	cap_word_t    rd_data;
	logic         capture_full;

	// case table from the cases file
	int          case_hold   [MAX_CASES];
	adc_sample_t case_base   [MAX_CASES];
	int          case_new_lo [MAX_CASES];
	int          case_new_hi [MAX_CASES];
	int          case_old_lo [MAX_CASES];
	int          case_old_hi [MAX_CASES];
	int          num_cases = 0;

	int          seed;
	int          cycle_limit  = 0;
	int          cycle_count  = 0;
	int          sample_index = 0;
	adc_sample_t run_base     = '0;

	tb_clock_gen #(
		.CLK_PERIOD_NS (100),
		.RESET_CYCLES  (RESET_CYCLES)
	) u_clock_gen (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n)
	);

	adc_capture_top DUT (
		.data_clk_div   (data_clk_div),
		.rst_n          (rst_n),
		.capture_enable (capture_enable),
		.adc_in         (adc_in),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data),
		.capture_full   (capture_full)
	);

	// chan_a of a sample, running index on top of the run base
	function automatic adc_sample_t channel_a_value(input int index, input adc_sample_t base);
		return (adc_sample_t'(index) & ADC_MASK) + base;
	endfunction

	// chan_a high, chan_b low as the inverse of chan_a
	function automatic sample_pair_t make_pair(input adc_sample_t a);
		sample_pair_t p;
		p.chan_a = a;
		p.chan_b = ~a & ADC_MASK;
		return p;
	endfunction

	function automatic adc_sample_t next_chan_a(input adc_sample_t a, input adc_sample_t base);
		return ((a - base + 16'd1) & ADC_MASK) + base;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input cap_word_t got, input cap_word_t exp, input string what);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH at %0t: %s, expected %h, got %h",
				$time, what, exp, got));
		end
	endtask

	task automatic check_full(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH at %0t: %s, expected %b, got %b",
				$time, what, exp, got));
		end
	endtask

	// new sample every falling edge
	always @(negedge data_clk_div) begin
		adc_in       <= make_pair(channel_a_value(sample_index, run_base));
		sample_index <= sample_index + 1;
	end

	always @(posedge data_clk_div) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			report_failure($sformatf("TIMEOUT: capture never completed within %0d cycles",
				cycle_limit));
		end
	end

	task automatic load_cases();
		int    fd;
		int    n;
		int    hold;
		int    base_val;
		int    new_lo;
		int    new_hi;
		int    old_lo;
		int    old_hi;
		string line;
		fd = $fopen("tests/capture_cases.txt", "r");
		if (fd == 0) begin
			report_failure("cannot open tests/capture_cases.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 0 && line[0] != "#") begin
				n = $sscanf(line, "%d %h %d %d %d %d",
					hold, base_val, new_lo, new_hi, old_lo, old_hi);
				if (n == 6) begin
					if (num_cases >= MAX_CASES) begin
						report_failure("too many lines in the cases file");
					end
					case_hold[num_cases]   = hold;
					case_base[num_cases]   = adc_sample_t'(base_val);
					case_new_lo[num_cases] = new_lo;
					case_new_hi[num_cases] = new_hi;
					case_old_lo[num_cases] = old_lo;
					case_old_hi[num_cases] = old_hi;
					num_cases++;
				end
			end
		end
		$fclose(fd);
	endtask

	// one cycle read latency, result taken on the next falling edge
	task automatic read_word(input cap_addr_t addr, output cap_word_t word);
		rd_addr = addr;
		@(negedge data_clk_div);
		word = rd_data;
	endtask

	// consecutive samples of one run, anchored on the first word read
	task automatic check_run_words(input int lo, input int hi, input adc_sample_t base,
		input string what);
		cap_word_t    got;
		sample_pair_t got_pair;
		adc_sample_t  a_exp;
		a_exp = '0;
		for (int addr = lo; addr <= hi; addr++) begin
			read_word(cap_addr_t'(addr), got);
			got_pair = got;
			if (addr == lo) begin
				a_exp = ((got_pair.chan_a - base) & ADC_MASK) + base;
			end
			check_word(got, make_pair(a_exp), $sformatf("%s word %0d", what, addr));
			a_exp = next_chan_a(a_exp, base);
		end
	endtask

	task automatic run_case(input int idx);
		int          hold;
		int          waited;
		int          idle;
		logic        expect_full;
		adc_sample_t prev_base;
		hold        = case_hold[idx];
		expect_full = (hold >= FULL_HOLD_MIN);
		prev_base   = run_base;
		run_base    = case_base[idx];
		waited      = 0;
		capture_enable = 1'b1;
		if (expect_full) begin
			while (capture_full !== 1'b1) begin
				@(negedge data_clk_div);
				waited++;
			end
			while (waited < hold) begin
				@(negedge data_clk_div);
				waited++;
				check_full(capture_full, 1'b1, "capture_full while holding");
			end
		end else begin
			while (waited < hold) begin
				@(negedge data_clk_div);
				waited++;
				check_full(capture_full, 1'b0, "capture_full during short capture");
			end
		end
		capture_enable = 1'b0;
		repeat (CLEAR_WAIT) @(negedge data_clk_div);
		check_full(capture_full, 1'b0, "capture_full after enable dropped");

		check_run_words(case_new_lo[idx], case_new_hi[idx], run_base, "new run");
		if (case_old_lo[idx] <= case_old_hi[idx]) begin
			check_run_words(case_old_lo[idx], case_old_hi[idx], prev_base, "previous run");
		end

		idle = IDLE_MIN + int'($unsigned($random(seed)) % (IDLE_MAX - IDLE_MIN + 1));
		repeat (idle) @(negedge data_clk_div);
	endtask

	initial begin
		seed           = 56;
		capture_enable = 1'b0;
		rd_addr        = '0;

		load_cases();
		if (num_cases == 0) begin
			report_failure("no capture cases found in tests/capture_cases.txt");
		end
		// hold, readback and idle budget per case
		cycle_limit = RESET_CYCLES;
		for (int i = 0; i < num_cases; i++) begin
			cycle_limit += (case_hold[i] > FULL_HOLD_MIN) ? case_hold[i] : FULL_HOLD_MIN;
			cycle_limit += CAPTURE_DEPTH + IDLE_MAX + CLEAR_WAIT;
		end

		wait (rst_n === 1'b1);
		@(negedge data_clk_div);
		check_full(capture_full, 1'b0, "capture_full after reset");

		for (int i = 0; i < num_cases; i++) begin
			run_case(i);
		end

		$display("Everything OK");
		$finish;
	end

endmodule

// ==== tests/capture_cases.txt ====
# ADC capture runs, one per line, executed in order
# columns: hold_cycles base_hex new_lo new_hi old_lo old_hi
# hold_cycles    cycles the enable stays high, 1100 or more expects a full memory
# base_hex       run base added to chan_a, upper bits only
# new_lo new_hi  addresses holding this run's samples
# old_lo old_hi  addresses still holding the previous run, none when old_lo > old_hi
1120 0000 1 1023 1 0
200 4000 1 150 300 1023
1120 8000 1 1023 1 0
120 c000 1 100 200 1023
1150 4000 1 1023 1 0
60 0000 1 50 100 1023

// ==== src.f ====
verilog/adc_sample_pkg.sv
verilog/capture_mem_pkg.sv
verilog/capture_enable_sync.sv
verilog/capture_addr_gen.sv
verilog/capture_ram.sv
verilog/adc_capture_top.sv
tests/tb_clock_gen.sv
tests/tb_adc_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the ADC capture testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	-f src.f --top-module tb_adc_capture \
	-Mdir obj_dir -o sim_adc_capture

./obj_dir/sim_adc_capture > sim.log 2>&1 || true
cat sim.log

if grep -q "Everything OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
